// File: src.f
verilog/bpu_pkg.sv
verilog/branch_table.sv
verilog/return_stack.sv
verilog/fetch_predict.sv
verilog/mispredict_unit.sv
verilog/branch_predictor.sv
testbench/tb_branch_predictor.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_branch_predictor \
  -f src.f -o tb_branch_predictor || exit 1
sim_out=$(./obj_dir/tb_branch_predictor)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/tb_branch_predictor.sv
// model assumes INDEX_BITS 9 and an 8-entry stack; random traffic stays in a 32-entry window
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

  logic clk = 1'b0;
  logic reset;
  logic [31:0] pc;
  logic resolve_valid;
  logic [31:0] resolve_pc;
  logic resolve_taken;
  logic [29:0] resolve_target;
  logic [1:0] resolve_type;
  logic resolve_pred_taken;
  logic [29:0] resolve_pred_target;
  wire [31:0] next_pc;
  wire [3:0] pc_valid;
  wire [3:0] pc_is_jump;
  wire flush;
  wire [31:0] flush_pc;
  wire [15:0] predict_count;
  wire [15:0] correct_count;

  // reference copy of the table, the stack and the counters
  logic m_valid [512];
  logic [20:0] m_tag [512];
  logic [1:0] m_cnt [512];
  logic [1:0] m_type [512];
  logic [29:0] m_tgt [512];
  logic [29:0] m_stack [8];
  logic [2:0] m_ptr;
  logic [15:0] m_predicts;
  logic [15:0] m_corrects;
  int errors = 0;

  branch_predictor #(
    .INDEX_BITS(9)
  ) branch_predictor_i (
    .clk(clk), .reset(reset), .pc(pc),
    .resolve_valid(resolve_valid), .resolve_pc(resolve_pc),
    .resolve_taken(resolve_taken), .resolve_target(resolve_target),
    .resolve_type(resolve_type), .resolve_pred_taken(resolve_pred_taken),
    .resolve_pred_target(resolve_pred_target),
    .next_pc(next_pc), .pc_valid(pc_valid), .pc_is_jump(pc_is_jump),
    .flush(flush), .flush_pc(flush_pc),
    .predict_count(predict_count), .correct_count(correct_count)
  );

  initial
  begin
    forever #20 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic next_edge();
    int changes;
    changes = 0;
    do
    begin
      @(clk);
      changes++;
    end
    while (clk !== 1'b1 && changes < 4);
    if (clk !== 1'b1)
    begin
      $display("clock did not rise within two periods");
      $display("tests failed");
      $finish;
    end
  endtask

  function automatic logic [31:0] random_pc();
    // two tags over 32 indices, so entries get reused and evicted
    return {20'h0, 1'($urandom), 4'h0, 5'($urandom), 2'b00};
  endfunction

  function automatic void predict_fetch(input logic [31:0] p, output logic [31:0] npc,
                                        output logic [3:0] vmask, output logic [3:0] jmask);
    logic [8:0] idx;
    logic found;
    found = 1'b0;
    npc = (p & 32'hffff_fff0) + 32'd16;
    vmask = 4'b0000;
    jmask = 4'b0000;
    for (int k = 0; k < 4; k++)
    begin
      idx = {p[10:4], 2'(k)};
      if (k >= int'(p[3:2]) && !found)
      begin
        vmask[k] = 1'b1;
        if (m_valid[idx] && m_tag[idx] == p[31:11] && m_cnt[idx] >= 2'd2)
        begin
          found = 1'b1;
          jmask[k] = 1'b1;
          if (m_type[idx] == bpu_pkg::JUMP_RETURN)
            npc = {m_stack[m_ptr - 3'd1], 2'b00};
          else
            npc = {m_tgt[idx], 2'b00};
        end
      end
    end
  endfunction

  function automatic void train_model();
    logic [8:0] idx;
    logic hit;
    idx = resolve_pc[10:2];
    hit = m_valid[idx] && (m_tag[idx] == resolve_pc[31:11]);
    if (resolve_taken)
    begin
      if (!hit)
      begin
        m_valid[idx] = 1'b1;
        m_tag[idx] = resolve_pc[31:11];
        m_cnt[idx] = 2'd2;
      end
      else if (m_cnt[idx] != 2'd3)
        m_cnt[idx] = m_cnt[idx] + 2'd1;
      m_type[idx] = resolve_type;
      m_tgt[idx] = resolve_target;
    end
    else if (hit && m_cnt[idx] != 2'd0)
      m_cnt[idx] = m_cnt[idx] - 2'd1;
    if (resolve_taken && resolve_type == bpu_pkg::JUMP_CALL)
    begin
      m_stack[m_ptr] = resolve_pc[31:2] + 30'd1;
      m_ptr = m_ptr + 3'd1;
    end
    else if (resolve_taken && resolve_type == bpu_pkg::JUMP_RETURN)
      m_ptr = m_ptr - 3'd1;
  endfunction

  // inputs are already driven; sample mid-cycle, then move to the next drive point
  task automatic run_cycle(input string name);
    logic [31:0] exp_npc;
    logic [3:0] exp_valid;
    logic [3:0] exp_jump;
    logic exp_flush;
    #18;
    predict_fetch(pc, exp_npc, exp_valid, exp_jump);
    check({name, " next_pc"}, exp_npc, next_pc);
    check({name, " pc_valid"}, 32'(exp_valid), 32'(pc_valid));
    check({name, " pc_is_jump"}, 32'(exp_jump), 32'(pc_is_jump));
    exp_flush = resolve_valid && ((resolve_taken != resolve_pred_taken) ||
                (resolve_taken && resolve_target != resolve_pred_target));
    check({name, " flush"}, 32'(exp_flush), 32'(flush));
    if (resolve_valid)
      check({name, " flush_pc"}, resolve_taken ? {resolve_target, 2'b00} : resolve_pc + 32'd4,
            flush_pc);
    check({name, " predict_count"}, 32'(m_predicts), 32'(predict_count));
    check({name, " correct_count"}, 32'(m_corrects), 32'(correct_count));
    if (resolve_valid)
    begin
      m_predicts = m_predicts + 16'd1;
      if (!exp_flush)
        m_corrects = m_corrects + 16'd1;
      train_model();
    end
    next_edge();
    #2;
    resolve_valid = 1'b0;
  endtask

  task automatic fetch(input string name, input logic [31:0] fetch_pc);
    pc = fetch_pc;
    run_cycle(name);
  endtask

  task automatic train(input string name, input logic [31:0] rpc, input logic tk,
                       input logic [29:0] tgt, input logic [1:0] ty, input logic [31:0] fetch_pc);
    resolve_valid = 1'b1;
    resolve_pc = rpc;
    resolve_taken = tk;
    resolve_target = tgt;
    resolve_type = ty;
    resolve_pred_taken = 1'($urandom);
    // half the time execute carried the right target
    resolve_pred_target = ($urandom % 2 == 0) ? tgt : 30'($urandom);
    fetch(name, fetch_pc);
  endtask

  initial
  begin
    reset = 1'b1;
    pc = '0;
    resolve_valid = 1'b0;
    resolve_pc = '0;
    resolve_taken = 1'b0;
    resolve_target = '0;
    resolve_type = '0;
    resolve_pred_taken = 1'b0;
    resolve_pred_target = '0;
    void'($urandom(32'hd178));
    for (int i = 0; i < 512; i++)
      m_valid[i] = 1'b0;
    m_ptr = '0;
    m_predicts = '0;
    m_corrects = '0;
    repeat (3) next_edge();
    #2;
    reset = 1'b0;

    for (int i = 0; i < 20; i++)
      fetch("empty_table", $urandom);

    // taken jump in slot 2, then a second one in slot 3
    train("direct_alloc", 32'h1008, 1'b1, 30'h0400, bpu_pkg::JUMP_DIRECT, 32'h1000);
    fetch("direct_hit", 32'h1000);
    fetch("direct_from_slot1", 32'h1004);
    train("second_jump", 32'h100c, 1'b1, 30'h0500, bpu_pkg::JUMP_DIRECT, 32'h1000);
    fetch("lower_slot_wins", 32'h1000);
    fetch("upper_slot_only", 32'h100c);

    // counter falls below taken, climbs back, then a new tag evicts
    train("not_taken_1", 32'h1008, 1'b0, 30'h0, bpu_pkg::JUMP_BRANCH, 32'h1000);
    train("not_taken_2", 32'h1008, 1'b0, 30'h0, bpu_pkg::JUMP_BRANCH, 32'h1000);
    fetch("prediction_gone", 32'h1000);
    train("taken_again_1", 32'h1008, 1'b1, 30'h0600, bpu_pkg::JUMP_BRANCH, 32'h1000);
    train("taken_again_2", 32'h1008, 1'b1, 30'h0600, bpu_pkg::JUMP_BRANCH, 32'h1000);
    fetch("prediction_back", 32'h1000);
    train("tag_replace", 32'h1808, 1'b1, 30'h0700, bpu_pkg::JUMP_DIRECT, 32'h1000);
    fetch("old_tag_evicted", 32'h1000);
    fetch("new_tag_hit", 32'h1800);

    // calls and returns through the stack
    train("call_a", 32'h2000, 1'b1, 30'h0c00, bpu_pkg::JUMP_CALL, 32'h4000);
    train("return_train", 32'h4004, 1'b1, 30'h0801, bpu_pkg::JUMP_RETURN, 32'h4000);
    train("call_a_again", 32'h2000, 1'b1, 30'h0c00, bpu_pkg::JUMP_CALL, 32'h4000);
    fetch("return_to_a", 32'h4000);
    train("call_b", 32'h2100, 1'b1, 30'h0d00, bpu_pkg::JUMP_CALL, 32'h4000);
    fetch("return_to_b", 32'h4000);
    train("return_b", 32'h4004, 1'b1, 30'h0841, bpu_pkg::JUMP_RETURN, 32'h4000);
    fetch("nested_return_to_a", 32'h4000);

    // every stack entry written before random returns can read it
    for (int i = 0; i < 8; i++)
      train("stack_fill", 32'h3000 + 32'(i * 64), 1'b1, 30'($urandom), bpu_pkg::JUMP_CALL,
            random_pc());
    for (int i = 0; i < 460; i++)
    begin
      if (i < 60 || $urandom % 2 == 0)
        train(i < 60 ? "random_resolve" : "random_mix", random_pc(), 1'($urandom),
              30'($urandom), 2'($urandom), random_pc());
      else
        fetch("random_mix", random_pc());
    end

    $display("errors: %0d", errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
// single execute port, one resolve per cycle never stalled; prediction is same-cycle on pc
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
  parameter int INDEX_BITS     = 9,
  parameter int RAS_DEPTH_BITS = 3
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire bpu_pkg::addr_t      pc,
  input  wire                      resolve_valid,
  input  wire bpu_pkg::addr_t      resolve_pc,
  input  wire                      resolve_taken,
  input  wire bpu_pkg::word_addr_t resolve_target,
  input  wire bpu_pkg::jump_type_t resolve_type,
  input  wire                      resolve_pred_taken,
  input  wire bpu_pkg::word_addr_t resolve_pred_target,
  output bpu_pkg::addr_t           next_pc,
  output bpu_pkg::slot_mask_t      pc_valid,
  output bpu_pkg::slot_mask_t      pc_is_jump,
  output logic                     flush,
  output bpu_pkg::addr_t           flush_pc,
  output logic [15:0]              predict_count,
  output logic [15:0]              correct_count
);

  bpu_pkg::slot_mask_t slot_hit;
  bpu_pkg::slot_mask_t slot_return;
  bpu_pkg::word_addr_t target0;
  bpu_pkg::word_addr_t target1;
  bpu_pkg::word_addr_t target2;
  bpu_pkg::word_addr_t target3;
  bpu_pkg::word_addr_t top_addr;

  branch_table #(
    .INDEX_BITS(INDEX_BITS)
  ) branch_table_i (
    .clk           (clk),
    .reset         (reset),
    .pc            (pc),
    .resolve_valid (resolve_valid),
    .resolve_pc    (resolve_pc),
    .resolve_taken (resolve_taken),
    .resolve_target(resolve_target),
    .resolve_type  (resolve_type),
    .slot_hit      (slot_hit),
    .slot_return   (slot_return),
    .target0       (target0),
    .target1       (target1),
    .target2       (target2),
    .target3       (target3)
  );

  return_stack #(
    .RAS_DEPTH_BITS(RAS_DEPTH_BITS)
  ) return_stack_i (
    .clk          (clk),
    .reset        (reset),
    .resolve_valid(resolve_valid),
    .resolve_pc   (resolve_pc),
    .resolve_taken(resolve_taken),
    .resolve_type (resolve_type),
    .top_addr     (top_addr)
  );

  fetch_predict fetch_predict_i (
    .pc         (pc),
    .slot_hit   (slot_hit),
    .slot_return(slot_return),
    .target0    (target0),
    .target1    (target1),
    .target2    (target2),
    .target3    (target3),
    .top_addr   (top_addr),
    .next_pc    (next_pc),
    .pc_valid   (pc_valid),
    .pc_is_jump (pc_is_jump)
  );

  mispredict_unit mispredict_unit_i (
    .clk                (clk),
    .reset              (reset),
    .resolve_valid      (resolve_valid),
    .resolve_pc         (resolve_pc),
    .resolve_taken      (resolve_taken),
    .resolve_target     (resolve_target),
    .resolve_pred_taken (resolve_pred_taken),
    .resolve_pred_target(resolve_pred_target),
    .flush              (flush),
    .flush_pc           (flush_pc),
    .predict_count      (predict_count),
    .correct_count      (correct_count)
  );

endmodule

`default_nettype wire

// File: verilog/mispredict_unit.sv
// trusts the prediction fields carried by execute; exception gating is left to the caller
`timescale 1ns/1ps
`default_nettype none

module mispredict_unit (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      resolve_valid,
  input  wire bpu_pkg::addr_t      resolve_pc,
  input  wire                      resolve_taken,
  input  wire bpu_pkg::word_addr_t resolve_target,
  input  wire                      resolve_pred_taken,
  input  wire bpu_pkg::word_addr_t resolve_pred_target,
  output logic                     flush,
  output bpu_pkg::addr_t           flush_pc,
  output logic [15:0]              predict_count,
  output logic [15:0]              correct_count
);

  logic dir_wrong;
  logic target_wrong;

  assign dir_wrong = resolve_taken != resolve_pred_taken;
  assign target_wrong = resolve_taken && resolve_pred_taken &&
                        (resolve_target != resolve_pred_target);

  assign flush = resolve_valid && (dir_wrong || target_wrong);

  // restart at the real target, or fall through past the branch
  assign flush_pc = resolve_taken ? {resolve_target, 2'b00} : resolve_pc + 32'd4;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      predict_count <= '0;
      correct_count <= '0;
    end
    else if (resolve_valid)
    begin
      predict_count <= predict_count + 16'd1;
      if (!flush)
      begin
        correct_count <= correct_count + 16'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fetch_predict.sv
// purely combinational; answers the pc of the same cycle, hits below pc[3:2] are ignored
`timescale 1ns/1ps
`default_nettype none

module fetch_predict (
  input  wire bpu_pkg::addr_t      pc,
  input  wire bpu_pkg::slot_mask_t slot_hit,
  input  wire bpu_pkg::slot_mask_t slot_return,
  input  wire bpu_pkg::word_addr_t target0,
  input  wire bpu_pkg::word_addr_t target1,
  input  wire bpu_pkg::word_addr_t target2,
  input  wire bpu_pkg::word_addr_t target3,
  input  wire bpu_pkg::word_addr_t top_addr,
  output bpu_pkg::addr_t           next_pc,
  output bpu_pkg::slot_mask_t      pc_valid,
  output bpu_pkg::slot_mask_t      pc_is_jump
);

  bpu_pkg::slot_mask_t group_mask;
  bpu_pkg::slot_mask_t live_hits;
  bpu_pkg::slot_mask_t jump_onehot;
  bpu_pkg::slot_mask_t thru_mask;
  logic                any_hit;
  logic                sel_return;
  bpu_pkg::word_addr_t sel_target;
  bpu_pkg::addr_t      seq_pc;

  // slots from the entry point upward
  assign group_mask = 4'b1111 << pc[3:2];
  assign live_hits = slot_hit & group_mask;
  assign any_hit = |live_hits;

  // lowest set bit wins
  assign jump_onehot = live_hits & (~live_hits + 4'd1);

  // slots 0 through the winner
  assign thru_mask = {jump_onehot[3], |jump_onehot[3:2], |jump_onehot[3:1], |jump_onehot};

  assign sel_target = ({30{jump_onehot[0]}} & target0) |
                      ({30{jump_onehot[1]}} & target1) |
                      ({30{jump_onehot[2]}} & target2) |
                      ({30{jump_onehot[3]}} & target3);
  assign sel_return = |(jump_onehot & slot_return);

  assign seq_pc = {pc[31:4] + 28'd1, 4'b0000};

  assign next_pc = !any_hit ? seq_pc : {(sel_return ? top_addr : sel_target), 2'b00};
  assign pc_valid = any_hit ? (group_mask & thru_mask) : group_mask;
  assign pc_is_jump = jump_onehot;

  // the taken slot must be one the fetch stage actually issues
  always_comb
  begin
    a_jump_onehot: assert final ($onehot0(pc_is_jump));
    a_jump_in_valid: assert final ((pc_is_jump & ~pc_valid) == 4'b0000);
  end

endmodule

`default_nettype wire

// File: verilog/return_stack.sv
// circular, so deep call chains overwrite the oldest entry; not repaired after a flush
`timescale 1ns/1ps
`default_nettype none

module return_stack #(
  parameter int RAS_DEPTH_BITS = 3
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      resolve_valid,
  input  wire bpu_pkg::addr_t      resolve_pc,
  input  wire                      resolve_taken,
  input  wire bpu_pkg::jump_type_t resolve_type,
  output bpu_pkg::word_addr_t      top_addr
);

  localparam int RAS_DEPTH = 1 << RAS_DEPTH_BITS;

  bpu_pkg::word_addr_t       ras_mem [RAS_DEPTH];
  logic [RAS_DEPTH_BITS-1:0] ptr;
  logic [RAS_DEPTH_BITS-1:0] top_ptr;
  logic                      push;
  logic                      pop;

  assign push = resolve_valid && resolve_taken && (resolve_type == bpu_pkg::JUMP_CALL);
  assign pop = resolve_valid && resolve_taken && (resolve_type == bpu_pkg::JUMP_RETURN);

  // entry just below the pointer, wraps at zero
  assign top_ptr = ptr - 1'b1;
  assign top_addr = ras_mem[top_ptr];

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ptr <= '0;
    end
    else if (push)
    begin
      // return lands on the word after the call
      ras_mem[ptr] <= resolve_pc[31:2] + 30'd1;
      ptr <= ptr + 1'b1;
    end
    else if (pop)
    begin
      ptr <= ptr - 1'b1;
    end
  end

  a_ptr_moves_on_call_return: assert property (
    @(posedge clk) disable iff (reset) !(push || pop) |=> (ptr == $past(ptr))
  );

endmodule

`default_nettype wire

// File: verilog/branch_table.sv
// needs INDEX_BITS >= 3; lookups see a training write only from the cycle after its strobe
`timescale 1ns/1ps
`default_nettype none

module branch_table #(
  parameter int INDEX_BITS = 9
) (
  input  wire                      clk,
  input  wire                      reset,
  input  wire bpu_pkg::addr_t      pc,
  input  wire                      resolve_valid,
  input  wire bpu_pkg::addr_t      resolve_pc,
  input  wire                      resolve_taken,
  input  wire bpu_pkg::word_addr_t resolve_target,
  input  wire bpu_pkg::jump_type_t resolve_type,
  output bpu_pkg::slot_mask_t      slot_hit,
  output bpu_pkg::slot_mask_t      slot_return,
  output bpu_pkg::word_addr_t      target0,
  output bpu_pkg::word_addr_t      target1,
  output bpu_pkg::word_addr_t      target2,
  output bpu_pkg::word_addr_t      target3
);

  localparam int TABLE_SIZE = 1 << INDEX_BITS;
  localparam int TAG_BITS = 30 - INDEX_BITS;

  logic [TABLE_SIZE-1:0] valid_q;
  logic [TAG_BITS-1:0]   tag_mem [TABLE_SIZE];
  bpu_pkg::counter_t     cnt_mem [TABLE_SIZE];
  bpu_pkg::jump_type_t   type_mem [TABLE_SIZE];
  bpu_pkg::word_addr_t   target_mem [TABLE_SIZE];

  logic [TAG_BITS-1:0]   rtag;
  logic [INDEX_BITS-1:0] ridx [4];
  bpu_pkg::word_addr_t   slot_target [4];

  logic [INDEX_BITS-1:0] widx;
  logic [TAG_BITS-1:0]   wtag;
  logic                  w_hit;
  bpu_pkg::counter_t     cnt_cur;
  bpu_pkg::counter_t     cnt_up;
  bpu_pkg::counter_t     cnt_down;

  // group read, slot k sits at base + k with base aligned to four
  assign rtag = pc[31:INDEX_BITS+2];

  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      ridx[k] = {pc[INDEX_BITS+1:4], 2'(k)};
      slot_hit[k] = valid_q[ridx[k]] && (tag_mem[ridx[k]] == rtag) &&
                    (cnt_mem[ridx[k]] >= 2'd2);
      slot_return[k] = slot_hit[k] && (type_mem[ridx[k]] == bpu_pkg::JUMP_RETURN);
      slot_target[k] = target_mem[ridx[k]];
    end
  end

  assign target0 = slot_target[0];
  assign target1 = slot_target[1];
  assign target2 = slot_target[2];
  assign target3 = slot_target[3];

  // training side
  assign widx = resolve_pc[INDEX_BITS+1:2];
  assign wtag = resolve_pc[31:INDEX_BITS+2];
  assign w_hit = valid_q[widx] && (tag_mem[widx] == wtag);
  assign cnt_cur = cnt_mem[widx];
  assign cnt_up = (cnt_cur == 2'd3) ? cnt_cur : cnt_cur + 2'd1;
  assign cnt_down = (cnt_cur == 2'd0) ? cnt_cur : cnt_cur - 2'd1;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q <= '0;
    end
    else if (resolve_valid)
    begin
      if (resolve_taken && !w_hit)
      begin
        // allocate, evicting whatever tag was there
        valid_q[widx] <= 1'b1;
        cnt_mem[widx] <= bpu_pkg::COUNTER_INIT;
        tag_mem[widx] <= wtag;
        type_mem[widx] <= resolve_type;
        target_mem[widx] <= resolve_target;
      end
      else if (w_hit)
      begin
        if (resolve_taken)
        begin
          cnt_mem[widx] <= cnt_up;
          type_mem[widx] <= resolve_type;
          target_mem[widx] <= resolve_target;
        end
        else
        begin
          cnt_mem[widx] <= cnt_down;
        end
      end
    end
  end

  // a resolve arriving during reset leaves its entry untouched
  a_reset_no_write: assert property (
    @(posedge clk) (reset && resolve_valid) |=>
      (cnt_mem[$past(widx)] === $past(cnt_mem[widx])) &&
      (tag_mem[$past(widx)] === $past(tag_mem[widx])) &&
      (type_mem[$past(widx)] === $past(type_mem[widx])) &&
      (target_mem[$past(widx)] === $past(target_mem[widx]))
  );

endmodule

`default_nettype wire

// File: verilog/bpu_pkg.sv
// widths assume 32-bit byte addresses and a fetch group of four word-aligned instructions
`default_nettype none

package bpu_pkg;

  // byte and word addresses
  typedef logic [31:0] addr_t;
  typedef logic [29:0] word_addr_t;

  // 2-bit saturating taken counter, taken when >= 2
  typedef logic [1:0] counter_t;

  // kind of control transfer
  typedef logic [1:0] jump_type_t;

  // one bit per instruction of the fetch group
  typedef logic [3:0] slot_mask_t;

  localparam jump_type_t JUMP_BRANCH = 2'd0;
  localparam jump_type_t JUMP_CALL   = 2'd1;
  localparam jump_type_t JUMP_RETURN = 2'd2;
  localparam jump_type_t JUMP_DIRECT = 2'd3;

  // weakly taken on allocation
  localparam counter_t COUNTER_INIT = 2'd2;

endpackage

`default_nettype wire
